//--- load_pkg.sv
// ------------------------------
// load unit package
// shared widths, data types and the enums for load operators
// and for the request state machine
// ------------------------------

package load_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // one data word and one virtual address are both 64 bits wide
    localparam int unsigned DATA_WIDTH         = 64;
    localparam int unsigned TRANS_ID_BITS      = 3;
    // the address checker compares only the offset inside a 4 KiB page
    localparam int unsigned PAGE_OFFSET_BITS   = 12;
    localparam int unsigned DCACHE_INDEX_WIDTH = 12;
    // tag bits sit directly above the index in the physical address
    localparam int unsigned DCACHE_TAG_WIDTH   = 44;
    localparam int unsigned BYTE_OFFSET_BITS   = 3;

    // ------------------------------
    // data types
    // ------------------------------
    typedef logic [DATA_WIDTH-1:0]       data_t;
    typedef logic [TRANS_ID_BITS-1:0]    trans_id_t;
    typedef logic [BYTE_OFFSET_BITS-1:0] byte_off_t;
    // one enable per byte of a data word
    typedef logic [DATA_WIDTH/8-1:0]     be_t;
    typedef logic [1:0]                  size_t;

    // transfer size codes as the data cache expects them
    localparam size_t SIZE_BYTE   = 2'd0;
    localparam size_t SIZE_HALF   = 2'd1;
    localparam size_t SIZE_WORD   = 2'd2;
    localparam size_t SIZE_DOUBLE = 2'd3;

    // integer load operators, the u suffix marks zero extension
    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_e;

    // states of the load request state machine
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } load_state_e;

endpackage

//--- load_op_decode.sv
// ------------------------------
// load operator decoder
// turns the operator and byte offset into transfer size, byte
// enables, signedness and the index of the byte holding the sign
// ------------------------------

`timescale 1ns/1ps

module load_op_decode (
    input  load_pkg::load_op_e  op_i,
    input  load_pkg::byte_off_t offset_i,
    output load_pkg::size_t     size_o,
    output load_pkg::be_t       be_o,
    output logic                signed_o,
    output load_pkg::byte_off_t sign_idx_o
);

    // byte enables of the access before it is moved to its offset
    load_pkg::be_t base_be;

    always_comb begin
        // a full double word is the fallback, its sign index is unused
        size_o     = load_pkg::SIZE_DOUBLE;
        base_be    = 8'hff;
        sign_idx_o = offset_i;

        unique case (op_i)
            load_pkg::LW, load_pkg::LWU: begin
                size_o     = load_pkg::SIZE_WORD;
                base_be    = 8'h0f;
                // the sign lives in the top byte of the four
                sign_idx_o = offset_i + 3'd3;
            end
            load_pkg::LH, load_pkg::LHU: begin
                size_o     = load_pkg::SIZE_HALF;
                base_be    = 8'h03;
                sign_idx_o = offset_i + 3'd1;
            end
            load_pkg::LB, load_pkg::LBU: begin
                size_o     = load_pkg::SIZE_BYTE;
                base_be    = 8'h01;
            end
            default: begin
                size_o     = load_pkg::SIZE_DOUBLE;
                base_be    = 8'hff;
            end
        endcase
    end

    // move the enables up to the first addressed byte
    assign be_o = base_be << offset_i;

    // only the plain word, half and byte loads extend their sign
    assign signed_o = op_i inside {load_pkg::LW, load_pkg::LH, load_pkg::LB};

endmodule

//--- load_request_fsm.sv
// ------------------------------
// load request state machine
// drives address translation, the page offset stall, the cache
// request and grant, the tag phase, kills and flushes
// ------------------------------

`timescale 1ns/1ps

module load_request_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic valid_i,
    input  logic page_offset_matches_i,
    input  logic gnt_i,
    input  logic dtlb_hit_i,
    output logic translation_req_o,
    output logic req_o,
    output logic tag_valid_o,
    output logic kill_o,
    output logic pop_ld_o,
    output logic flushing_o
);

    load_pkg::load_state_e state_d, state_q;

    // ------------------------------
    // next state and outputs
    // ------------------------------
    always_comb begin
        state_d           = state_q;
        translation_req_o = 1'b0;
        req_o             = 1'b0;
        tag_valid_o       = 1'b0;
        kill_o            = 1'b0;
        pop_ld_o          = 1'b0;

        unique case (state_q)
            // a new request is taken both from idle and while the tag
            // of the previous load goes out
            load_pkg::IDLE, load_pkg::SEND_TAG: begin
                // the tag follows its grant by exactly one cycle
                tag_valid_o = (state_q == load_pkg::SEND_TAG);
                state_d     = load_pkg::IDLE;
                if (valid_i) begin
                    // translation starts before the page offset check
                    // has settled, which keeps the TLB path short
                    translation_req_o = 1'b1;
                    if (page_offset_matches_i) begin
                        // a store to the same page offset is pending
                        state_d = load_pkg::WAIT_PAGE_OFFSET;
                    end else begin
                        req_o = 1'b1;
                        if (!gnt_i) begin
                            state_d = load_pkg::WAIT_GNT;
                        end else if (dtlb_hit_i) begin
                            // granted and translated, send the tag next cycle
                            state_d  = load_pkg::SEND_TAG;
                            pop_ld_o = 1'b1;
                        end else begin
                            state_d = load_pkg::ABORT_TRANSACTION;
                        end
                    end
                end
            end

            // hold off until the store buffer no longer matches
            load_pkg::WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = load_pkg::WAIT_GNT;
                end
            end

            // request and translation stay up until the cache grants
            load_pkg::WAIT_GNT: begin
                translation_req_o = 1'b1;
                req_o             = 1'b1;
                if (gnt_i) begin
                    if (dtlb_hit_i) begin
                        state_d  = load_pkg::SEND_TAG;
                        pop_ld_o = 1'b1;
                    end else begin
                        state_d = load_pkg::ABORT_TRANSACTION;
                    end
                end
            end

            // the TLB missed at the grant, so the cache slot is freed
            // and the page table walker gets the way to the cache
            load_pkg::ABORT_TRANSACTION: begin
                kill_o      = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = load_pkg::WAIT_TRANSLATION;
            end

            // retry the request once the translation is in the TLB
            load_pkg::WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = load_pkg::WAIT_GNT;
                end
            end

            // cancel whatever the cache still has in flight for us
            load_pkg::WAIT_FLUSH: begin
                kill_o      = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = load_pkg::IDLE;
            end

            default: begin
                state_d = load_pkg::IDLE;
            end
        endcase

        // a flush wins over every other transition
        if (flush_i) begin
            state_d = load_pkg::WAIT_FLUSH;
        end
    end

    // the result side drops any response that lands in this state
    assign flushing_o = (state_q == load_pkg::WAIT_FLUSH);

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= load_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- load_result_align.sv
// ------------------------------
// load result aligner
// keeps the metadata of the outstanding load, aligns and extends
// the returned cache word and raises the retire strobe
// ------------------------------

`timescale 1ns/1ps

module load_result_align (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                pop_ld_i,
    input  logic                kill_i,
    input  logic                flushing_i,
    input  logic                rvalid_i,
    input  load_pkg::trans_id_t trans_id_i,
    input  load_pkg::load_op_e  op_i,
    input  load_pkg::byte_off_t offset_i,
    input  load_pkg::byte_off_t sign_idx_i,
    input  logic                signed_i,
    input  load_pkg::data_t     rdata_i,
    output logic                valid_o,
    output load_pkg::trans_id_t trans_id_o,
    output load_pkg::data_t     result_o
);

    load_pkg::trans_id_t trans_id_q;
    load_pkg::load_op_e  op_q;
    load_pkg::byte_off_t offset_q;
    load_pkg::byte_off_t sign_idx_q;
    logic                signed_q;

    load_pkg::data_t     shifted_data;
    logic [7:0]          sign_bits;
    logic                sign_bit;

    // ------------------------------
    // load metadata
    // ------------------------------
    // captured when the request pops, the cache answers later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trans_id_q <= '0;
            op_q       <= load_pkg::LD;
            offset_q   <= '0;
            sign_idx_q <= '0;
            signed_q   <= 1'b0;
        end else if (pop_ld_i) begin
            trans_id_q <= trans_id_i;
            op_q       <= op_i;
            offset_q   <= offset_i;
            sign_idx_q <= sign_idx_i;
            signed_q   <= signed_i;
        end
    end

    // ------------------------------
    // align and extend
    // ------------------------------
    // bring the addressed byte down to bit 0
    assign shifted_data = rdata_i >> {offset_q, 3'b000};

    // top bit of every byte, picked in parallel with the shifter
    always_comb begin
        for (int unsigned k = 0; k < 8; k++) begin
            sign_bits[k] = rdata_i[8*k+7];
        end
    end

    // zero for the unsigned loads
    assign sign_bit = signed_q & sign_bits[sign_idx_q];

    always_comb begin
        unique case (op_q)
            load_pkg::LW, load_pkg::LWU: result_o = {{32{sign_bit}}, shifted_data[31:0]};
            load_pkg::LH, load_pkg::LHU: result_o = {{48{sign_bit}}, shifted_data[15:0]};
            load_pkg::LB, load_pkg::LBU: result_o = {{56{sign_bit}}, shifted_data[7:0]};
            default:                     result_o = shifted_data;
        endcase
    end

    // a response is dropped while flushing or when it meets a kill
    assign valid_o    = rvalid_i & ~flushing_i & ~kill_i;
    assign trans_id_o = trans_id_q;

endmodule

//--- load_unit.sv
// ------------------------------
// load unit top level
// connects operator decoder, request state machine and result
// aligner to the issue, TLB, address checker and cache ports
// ------------------------------

`timescale 1ns/1ps

module load_unit (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       flush_i,
    // issue side
    input  logic                                       valid_i,
    input  load_pkg::data_t                            vaddr_i,
    input  load_pkg::trans_id_t                        trans_id_i,
    input  load_pkg::load_op_e                         op_i,
    output logic                                       pop_ld_o,
    // retire side
    output logic                                       valid_o,
    output load_pkg::trans_id_t                        trans_id_o,
    output load_pkg::data_t                            result_o,
    // address translation
    output logic                                       translation_req_o,
    output load_pkg::data_t                            vaddr_o,
    input  load_pkg::data_t                            paddr_i,
    input  logic                                       dtlb_hit_i,
    // address checker
    output logic [load_pkg::PAGE_OFFSET_BITS-1:0]      page_offset_o,
    input  logic                                       page_offset_matches_i,
    // data cache
    output logic                                       req_o,
    input  logic                                       gnt_i,
    output logic [load_pkg::DCACHE_INDEX_WIDTH-1:0]    index_o,
    output logic [load_pkg::DCACHE_TAG_WIDTH-1:0]      tag_o,
    output load_pkg::size_t                            size_o,
    output load_pkg::be_t                              be_o,
    output logic                                       tag_valid_o,
    output logic                                       kill_o,
    input  logic                                       rvalid_i,
    input  load_pkg::data_t                            rdata_i
);

    load_pkg::byte_off_t offset;
    load_pkg::byte_off_t sign_idx;
    logic                is_signed;
    logic                flushing;

    // ------------------------------
    // address fields
    // ------------------------------
    assign vaddr_o       = vaddr_i;
    assign page_offset_o = vaddr_i[load_pkg::PAGE_OFFSET_BITS-1:0];
    // the index is untranslated, the tag comes from last cycle's paddr
    assign index_o       = vaddr_i[load_pkg::DCACHE_INDEX_WIDTH-1:0];
    assign tag_o         = paddr_i[load_pkg::DCACHE_TAG_WIDTH+load_pkg::DCACHE_INDEX_WIDTH-1:
                                   load_pkg::DCACHE_INDEX_WIDTH];
    assign offset        = vaddr_i[load_pkg::BYTE_OFFSET_BITS-1:0];

    load_op_decode i_op_decode (
        .op_i       (op_i),
        .offset_i   (offset),
        .size_o     (size_o),
        .be_o       (be_o),
        .signed_o   (is_signed),
        .sign_idx_o (sign_idx)
    );

    load_request_fsm i_request_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .page_offset_matches_i (page_offset_matches_i),
        .gnt_i                 (gnt_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .translation_req_o     (translation_req_o),
        .req_o                 (req_o),
        .tag_valid_o           (tag_valid_o),
        .kill_o                (kill_o),
        .pop_ld_o              (pop_ld_o),
        .flushing_o            (flushing)
    );

    load_result_align i_result_align (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .pop_ld_i   (pop_ld_o),
        .kill_i     (kill_o),
        .flushing_i (flushing),
        .rvalid_i   (rvalid_i),
        .trans_id_i (trans_id_i),
        .op_i       (op_i),
        .offset_i   (offset),
        .sign_idx_i (sign_idx),
        .signed_i   (is_signed),
        .rdata_i    (rdata_i),
        .valid_o    (valid_o),
        .trans_id_o (trans_id_o),
        .result_o   (result_o)
    );

endmodule

//--- load_unit_tb.sv
// ------------------------------
// load unit testbench
// table driven loads against TLB, address checker and cache
// models, with results checked against the extension rules
// ------------------------------

`timescale 1ns/1ps

module load_unit_tb;

    localparam int MAX_ROWS = 40;

    logic                rst_ni, clk_i, flush_i, valid_i, pop_ld_o, valid_o;
    load_pkg::data_t     vaddr_i, result_o, vaddr_o, paddr_i, rdata_i;
    load_pkg::trans_id_t trans_id_i, trans_id_o;
    load_pkg::load_op_e  op_i;
    logic                translation_req_o, dtlb_hit_i, page_offset_matches_i;
    logic                req_o, gnt_i, tag_valid_o, kill_o, rvalid_i;
    logic [load_pkg::PAGE_OFFSET_BITS-1:0]   page_offset_o;
    logic [load_pkg::DCACHE_INDEX_WIDTH-1:0] index_o;
    logic [load_pkg::DCACHE_TAG_WIDTH-1:0]   tag_o;
    load_pkg::size_t     size_o;
    load_pkg::be_t       be_o;

    // stimulus table, one entry per load
    load_pkg::data_t     tab_vaddr [MAX_ROWS];
    load_pkg::load_op_e  tab_op    [MAX_ROWS];
    int                  tab_gnt   [MAX_ROWS];
    int                  tab_miss  [MAX_ROWS];
    int                  tab_match [MAX_ROWS];
    bit                  tab_flush [MAX_ROWS];
    int                  tab_resp  [MAX_ROWS];
    int                  n_rows;
    int                  cycle_cnt;
    int                  timeout_limit;

    load_unit i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------
    // error handling and checks
    // ------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_data(input string name, input load_pkg::data_t act,
                              input load_pkg::data_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name, input load_pkg::trans_id_t act,
                            input load_pkg::trans_id_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name,
                             input logic [load_pkg::DCACHE_TAG_WIDTH-1:0] act,
                             input logic [load_pkg::DCACHE_TAG_WIDTH-1:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr_field(input string name,
                                    input logic [load_pkg::PAGE_OFFSET_BITS-1:0] act,
                                    input logic [load_pkg::PAGE_OFFSET_BITS-1:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input load_pkg::size_t act,
                              input load_pkg::size_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_be(input string name, input load_pkg::be_t act,
                            input load_pkg::be_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int act, input int exp);
        if (act != exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int op_bytes(input load_pkg::load_op_e op);
        case (op)
            load_pkg::LD:                op_bytes = 8;
            load_pkg::LW, load_pkg::LWU: op_bytes = 4;
            load_pkg::LH, load_pkg::LHU: op_bytes = 2;
            default:                     op_bytes = 1;
        endcase
    endfunction

    // the addressed bytes moved down to bit 0, then sign or zero filled
    function automatic load_pkg::data_t expected_result(input load_pkg::load_op_e op,
                                                        input int off,
                                                        input load_pkg::data_t word);
        load_pkg::data_t sh;
        sh = word >> (8 * off);
        case (op)
            load_pkg::LW:  expected_result = {{32{sh[31]}}, sh[31:0]};
            load_pkg::LWU: expected_result = {32'b0, sh[31:0]};
            load_pkg::LH:  expected_result = {{48{sh[15]}}, sh[15:0]};
            load_pkg::LHU: expected_result = {48'b0, sh[15:0]};
            load_pkg::LB:  expected_result = {{56{sh[7]}}, sh[7:0]};
            load_pkg::LBU: expected_result = {56'b0, sh[7:0]};
            default:       expected_result = sh;
        endcase
    endfunction

    task automatic add_row(input load_pkg::data_t va, input load_pkg::load_op_e op,
                           input int gnt, input int miss, input int match,
                           input bit flush, input int resp);
        tab_vaddr[n_rows] = va;
        tab_op[n_rows]    = op;
        tab_gnt[n_rows]   = gnt;
        tab_miss[n_rows]  = miss;
        tab_match[n_rows] = match;
        tab_flush[n_rows] = flush;
        tab_resp[n_rows]  = resp;
        n_rows++;
    endtask

    // one load from issue to retire, the cache and TLB models act per cycle
    task automatic run_row(input int r);
        load_pkg::data_t     exp_paddr, exp_word;
        load_pkg::trans_id_t id;
        load_pkg::size_t     exp_size;
        load_pkg::be_t       exp_be;
        logic [7:0]          seed;
        int                  req_wait, miss_cnt, match_cnt, since_tag, cyc;
        int                  valid_seen, kills;
        bit                  popped, pop_prev, hit_prev, resp_pending, flushed, done;
        id           = load_pkg::trans_id_t'(r % 8);
        seed         = 8'($urandom) & 8'h7f;
        exp_paddr    = tab_vaddr[r] + 64'h8000_0000;
        // size code is log2 of the byte count
        exp_size     = load_pkg::size_t'($clog2(op_bytes(tab_op[r])));
        // one enable per accessed byte, moved up to the byte offset
        exp_be       = load_pkg::be_t'(((1 << op_bytes(tab_op[r])) - 1) << tab_vaddr[r][2:0]);
        {req_wait, miss_cnt, match_cnt, since_tag, cyc, valid_seen, kills} = '0;
        {popped, pop_prev, hit_prev, resp_pending, flushed, done} = '0;
        // with the seed below 0x80 the sign of each byte comes from its address
        for (int k = 0; k < 8; k++) begin
            exp_word[8*k +: 8] = ((exp_paddr[7:0] & 8'hf8) + 8'(k)) ^ seed;
        end
        vaddr_i    = tab_vaddr[r];
        trans_id_i = id;
        op_i       = tab_op[r];
        while (!done) begin
            @(negedge clk_i);
            valid_i               = !popped && !flushed;
            page_offset_matches_i = (match_cnt < tab_match[r]);
            dtlb_hit_i            = (miss_cnt >= tab_miss[r]);
            paddr_i               = hit_prev ? exp_paddr : '0;
            gnt_i                 = (req_wait >= tab_gnt[r]) && !resp_pending;
            flush_i               = tab_flush[r] && !flushed && (req_wait == 2);
            rvalid_i              = resp_pending && (since_tag == tab_resp[r]);
            rdata_i               = rvalid_i ? exp_word : '0;
            #10;
            check_data("vaddr_o", vaddr_o, tab_vaddr[r]);
            check_addr_field("page_offset_o", page_offset_o, tab_vaddr[r][11:0]);
            // index, size and enables are valid for as long as the request is up
            if (req_o) begin
                check_addr_field("index_o", index_o, tab_vaddr[r][11:0]);
                check_size("size_o", size_o, exp_size);
                check_be("be_o", be_o, exp_be);
            end
            if (page_offset_matches_i && (req_o || pop_ld_o)) begin
                protocol_error("request raised during a page offset match");
            end
            if (pop_ld_o && !req_o) begin
                protocol_error("pop_ld_o without req_o");
            end
            if (pop_ld_o && cyc != 0 && tab_gnt[r] == 0 && tab_miss[r] == 0
                    && tab_match[r] == 0) begin
                protocol_error("pop_ld_o late on an immediate grant and hit");
            end
            if (pop_prev != (tag_valid_o && !kill_o)) begin
                protocol_error("tag_valid_o not exactly one cycle after pop_ld_o");
            end
            if (valid_o != rvalid_i) begin
                protocol_error("valid_o does not match the cache response");
            end
            if (tag_valid_o && kill_o) begin
                kills++;
            end
            if (valid_o) begin
                valid_seen++;
            end
            if (rvalid_i) begin
                resp_pending = 1'b0;
                check_data("result_o", result_o,
                           expected_result(tab_op[r], tab_vaddr[r][2:0], exp_word));
                check_id("trans_id_o", trans_id_o, id);
                done = 1'b1;
            end
            if (resp_pending) begin
                since_tag++;
            end
            // the tag opens the response window of the cache model
            if (tag_valid_o && !kill_o) begin
                check_tag("tag_o", tag_o, exp_paddr[55:12]);
                resp_pending = 1'b1;
                since_tag    = 1;
            end
            if (flushed && kill_o && tag_valid_o) begin
                done = 1'b1;
            end
            if (req_o && !gnt_i) req_wait++;
            if (translation_req_o && !dtlb_hit_i) miss_cnt++;
            if (valid_i) match_cnt++;
            hit_prev = translation_req_o && dtlb_hit_i;
            pop_prev = pop_ld_o;
            popped   = popped || pop_ld_o;
            flushed  = flushed || flush_i;
            cyc++;
        end
        check_count("valid_o", valid_seen, tab_flush[r] ? 0 : 1);
        check_count("kill_o", kills, (tab_flush[r] || tab_miss[r] > 0) ? 1 : 0);
    endtask

    // ------------------------------
    // timeout
    // ------------------------------
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            abort_run();
        end
    end

    initial begin
        load_pkg::load_op_e op;
        load_pkg::data_t    base;
        void'($urandom(32'hdfae_2416));
        {rst_ni, flush_i, valid_i, dtlb_hit_i, page_offset_matches_i} = '0;
        {gnt_i, rvalid_i} = '0;
        {vaddr_i, paddr_i, rdata_i} = '0;
        trans_id_i = '0;
        op_i       = load_pkg::LD;
        n_rows     = 0;
        cycle_cnt  = 0;
        base       = 64'h0000_00ab_cdef_1040;
        // every operator at each of its legal offsets
        for (int o = 0; o < 7; o++) begin
            op = load_pkg::load_op_e'(o);
            for (int off = 0; off < 8; off += op_bytes(op)) begin
                add_row(base + (n_rows << 6) + off, op, n_rows % 3, 0, 0, 1'b0,
                        1 + n_rows % 3);
            end
        end
        // TLB miss at the grant, page offset stall, flush, then a normal load
        add_row(base + (n_rows << 6) + 3, load_pkg::LB,  0, 2, 0, 1'b0, 2);
        add_row(base + (n_rows << 6) + 4, load_pkg::LW,  1, 0, 3, 1'b0, 3);
        add_row(base + (n_rows << 6) + 2, load_pkg::LH,  6, 0, 0, 1'b1, 1);
        add_row(base + (n_rows << 6) + 6, load_pkg::LHU, 0, 0, 0, 1'b0, 2);
        timeout_limit = 40 * n_rows + 10;

        repeat (4) @(posedge clk_i);
        check_count("control outputs in reset", pop_ld_o + req_o + tag_valid_o + kill_o
                    + translation_req_o + valid_o, 0);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        // nothing may retire once the table is done
        @(negedge clk_i);
        {valid_i, gnt_i, rvalid_i} = '0;
        repeat (4) begin
            #10;
            check_count("valid_o after the last load", valid_o, 0);
            @(negedge clk_i);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- all.f
load_pkg.sv
load_op_decode.sv
load_request_fsm.sv
load_result_align.sv
load_unit.sv
load_unit_tb.sv

//--- Bender.yml
package:
  name: load_unit

sources:
  - load_pkg.sv
  - load_op_decode.sv
  - load_request_fsm.sv
  - load_result_align.sv
  - load_unit.sv
  - target: simulation
    files:
      - load_unit_tb.sv
